/* common/flash_pkg.sv */
package flash_pkg;

	// ##########################################################
	// Bus and datapath widths
	// ##########################################################

	typedef logic [15:0] reg_word_t;   // Host register bus word.
	typedef logic [3:0]  reg_addr_t;   // Register offset.
	typedef logic [23:0] flash_addr_t; // Flash byte address.
	typedef logic [15:0] mem_addr_t;   // Destination word address.
	typedef logic [15:0] mem_data_t;   // Destination data word.
	typedef logic [5:0]  xfer_len_t;   // SPI transfer length in bits.

	// ##########################################################
	// Register map
	// ##########################################################

	localparam reg_addr_t REG_ADDR_LO   = 4'd0;
	localparam reg_addr_t REG_ADDR_HI   = 4'd1; // Bits 7:0 only.
	localparam reg_addr_t REG_CMD       = 4'd2; // Bit 0 go-read, bit 1 wake.
	localparam reg_addr_t REG_DATA      = 4'd3;
	localparam reg_addr_t REG_STATUS    = 4'd4; // Bit 0 done, bit 1 busy.
	localparam reg_addr_t REG_DMA_ADDR  = 4'd5;
	localparam reg_addr_t REG_DMA_COUNT = 4'd6;

	// Flash opcodes.
	localparam logic [7:0] OP_READ = 8'h03;
	localparam logic [7:0] OP_WAKE = 8'hAB;

	// ##########################################################
	// Sequencer states
	// ##########################################################

	typedef enum logic [2:0] {
		seq_idle,
		seq_wake,     // Wake opcode on the wire.
		seq_cmd_addr, // Read opcode plus 24-bit address.
		seq_data,     // Shifting in one 16-bit word.
		seq_mem_wr,   // Word waiting on the memory port.
		seq_finish
	} seq_state_t;

endpackage

/* common/mem_wr_if.sv */
`timescale 1ns/1ps

interface mem_wr_if import flash_pkg::*; ();

	logic      wvalid;
	logic      wready;
	mem_addr_t memory_address;
	mem_data_t memory_data;

	modport source (
		output wvalid, memory_address, memory_data,
		input  wready
	);

	modport sink (
		input  wvalid, memory_address, memory_data,
		output wready
	);

endinterface

/* common/spi_if.sv */
`timescale 1ns/1ps

interface spi_if import flash_pkg::*; ();

	logic        start;   // One-cycle request, only while the shifter is idle.
	logic [31:0] tx_data; // Sent MSB first.
	xfer_len_t   tx_len;
	mem_data_t   rx_data; // Last 16 bits sampled.
	logic        done;

	modport master (
		output start, tx_data, tx_len,
		input  rx_data, done
	);

	modport slave (
		input  start, tx_data, tx_len,
		output rx_data, done
	);

endinterface

/* compile.f */
common/flash_pkg.sv
common/spi_if.sv
common/mem_wr_if.sv
spi_flash/flash_regs.sv
spi_flash/flash_seq.sv
spi_flash/spi_shifter.sv
logic/spi_flash_dma.sv
dv/flash_model.sv
dv/tb_spi_flash_dma.sv

/* dv/flash_model.sv */
`timescale 1ns/1ps

module flash_model import flash_pkg::*; (
	input  logic CSb,
	input  logic SCK,
	input  logic MOSI,
	output logic MISO
);

	logic        awake = 1'b0; // Deep power-down after power-up.
	logic        miso_r = 1'b1;
	logic [31:0] shift_in;
	logic [7:0]  opcode;
	flash_addr_t rd_addr;
	int          bit_cnt = 0;
	int          data_bit;
	logic [7:0]  cur_byte;

	function automatic logic [7:0] pattern(flash_addr_t a);
		logic [7:0] p;
		p = a[7:0] * 8'd7;
		return p ^ 8'h5A;
	endfunction

	// ##########################################################
	// Command and address capture
	// ##########################################################

	always @(posedge SCK or posedge CSb) begin
		if (CSb !== 1'b0) begin
			// Release from power-down once a full wake opcode was seen.
			if (bit_cnt == 8 && opcode == OP_WAKE)
				awake = 1'b1;
			bit_cnt = 0;
		end else begin
			shift_in = {shift_in[30:0], MOSI}; // Mode 0, sampled on rising SCK.
			bit_cnt  = bit_cnt + 1;
			if (bit_cnt == 8)
				opcode = shift_in[7:0];
			if (bit_cnt == 32)
				rd_addr = shift_in[23:0];
		end
	end

	// ##########################################################
	// Read data
	// ##########################################################

	// Next bit goes out on falling SCK, MSB first.
	always @(negedge SCK) begin
		if (CSb === 1'b0 && opcode == OP_READ && bit_cnt >= 32) begin
			data_bit = bit_cnt - 32;
			cur_byte = pattern(rd_addr + 24'(data_bit / 8)); // Address auto-increments.
			if (awake)
				miso_r = cur_byte[3'(7 - data_bit % 8)];
			else
				miso_r = 1'b1; // Asleep, reads as 0xFF.
		end
	end

	assign MISO = miso_r;

endmodule

/* dv/tb_spi_flash_dma.sv */
`timescale 1ns/1ps

module tb_spi_flash_dma import flash_pkg::*; ();

	localparam int SCK_DIV = 8;
	// Bits of the asleep read, wake and read, throttled read, busy and high address tests.
	localparam int TEST_BITS = 64 + 104 + 96 + 80 + 80;
	localparam int LIMIT = TEST_BITS * SCK_DIV * 4 + 2000;

	logic      CLK = 1'b0;
	logic      RSTb;
	reg_addr_t address;
	reg_word_t data_in;
	logic      wr;
	reg_word_t data_out;
	logic      MOSI;
	logic      MISO;
	logic      SCK;
	logic      CSb;
	logic      wvalid;
	logic      wready = 1'b1;
	mem_addr_t memory_address;
	mem_data_t memory_data;
	logic      irq;

	int        errors = 0;
	int        checks = 0;
	int        cycles = 0;
	int        irq_count = 0;
	int        irq_base = 0;
	int        wr_base = 0;
	logic      throttle = 1'b0;
	logic [7:0] lfsr = 8'd19;
	logic      held = 1'b0;
	logic      moved = 1'b0;
	mem_addr_t held_addr;
	mem_data_t held_data;
	mem_addr_t seen_addr[$];
	mem_data_t seen_data[$];

	spi_flash_dma #(.SCK_DIV(SCK_DIV)) DUT (
		.CLK (CLK), .RSTb (RSTb), .address (address), .data_in (data_in), .wr (wr),
		.data_out (data_out), .MOSI (MOSI), .MISO (MISO), .SCK (SCK), .CSb (CSb),
		.wvalid (wvalid), .wready (wready), .memory_address (memory_address),
		.memory_data (memory_data), .irq (irq)
	);

	flash_model u_flash (.CSb (CSb), .SCK (SCK), .MOSI (MOSI), .MISO (MISO));

	always #10 CLK = ~CLK;

	// ##########################################################
	// Reference values and checks
	// ##########################################################

	function automatic logic [7:0] pattern(flash_addr_t a);
		logic [7:0] p;
		p = a[7:0] * 8'd7;
		return p ^ 8'h5A;
	endfunction

	function automatic mem_data_t expected_word(flash_addr_t a);
		return {pattern(a + 24'd1), pattern(a)}; // First flash byte low.
	endfunction

	function automatic logic [7:0] lfsr_next(logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic check_word(string name, reg_word_t got, reg_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_mem_addr(string name, mem_addr_t got, mem_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	// ##########################################################
	// Memory responder and run limit
	// ##########################################################

	always @(posedge CLK) begin
		if (RSTb) begin
			if (held) begin // A write that stalled last cycle must hold.
				check_bit("wvalid", wvalid, 1'b1);
				check_mem_addr("memory_address", memory_address, held_addr);
				check_word("memory_data", memory_data, held_data);
			end
			if (moved)
				check_bit("wvalid", wvalid, 1'b0);
			if (irq)
				irq_count++;
			if (wvalid && wready) begin
				seen_addr.push_back(memory_address);
				seen_data.push_back(memory_data);
			end
			held      = wvalid && !wready;
			moved     = wvalid && wready;
			held_addr = memory_address;
			held_data = memory_data;
		end
		if (throttle) begin
			lfsr = lfsr_next(lfsr);
			wready <= lfsr[0];
		end else begin
			wready <= 1'b1;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the DUT did not finish within %0d cycles", LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	// ##########################################################
	// Register bus helpers
	// ##########################################################

	task automatic write_reg(reg_addr_t a, reg_word_t d);
		@(posedge CLK);
		address <= a;
		data_in <= d;
		wr      <= 1'b1;
		@(posedge CLK);
		wr <= 1'b0;
	endtask

	task automatic expect_reg(string name, reg_addr_t a, reg_word_t exp);
		@(posedge CLK);
		address <= a;
		@(negedge CLK); // Read mux settles mid-cycle.
		check_word(name, data_out, exp);
	endtask

	task automatic start_read(flash_addr_t fa, mem_addr_t da, reg_word_t n);
		write_reg(REG_ADDR_LO, fa[15:0]);
		write_reg(REG_ADDR_HI, {8'h00, fa[23:16]});
		write_reg(REG_DMA_ADDR, da);
		write_reg(REG_DMA_COUNT, n);
		irq_base = irq_count;
		wr_base  = seen_addr.size();
		write_reg(REG_CMD, 16'h0001);
	endtask

	task automatic await_irq();
		while (irq_count == irq_base)
			@(negedge CLK);
	endtask

	task automatic close_checks(int n);
		if (irq_count != irq_base + 1) begin
			errors++;
			$display("Expected one irq pulse but counted %0d", irq_count - irq_base);
		end
		if (seen_addr.size() - wr_base != n) begin
			errors++;
			$display("Expected %0d memory writes but saw %0d", n, seen_addr.size() - wr_base);
		end
		check_bit("CSb", CSb, 1'b1);
		expect_reg("status", REG_STATUS, 16'h0001);
	endtask

	task automatic compare_words(mem_addr_t da, flash_addr_t fa, int n, logic asleep);
		mem_data_t exp;
		for (int i = 0; i < n && wr_base + i < seen_addr.size(); i++) begin
			exp = asleep ? 16'hFFFF : expected_word(fa + 24'(2 * i));
			check_mem_addr("memory_address", seen_addr[wr_base + i], da + 16'(i));
			check_word("memory_data", seen_data[wr_base + i], exp);
		end
	endtask

	// ##########################################################
	// Directed tests
	// ##########################################################

	task automatic test_reset_state();
		check_bit("CSb", CSb, 1'b1);
		check_bit("SCK", SCK, 1'b0);
		check_bit("MOSI", MOSI, 1'b0);
		check_bit("wvalid", wvalid, 1'b0);
		check_bit("irq", irq, 1'b0);
		expect_reg("status", REG_STATUS, 16'h0000);
		expect_reg("data", REG_DATA, 16'h0000);
	endtask

	task automatic test_read_asleep();
		start_read(24'h000000, 16'h0010, 16'd2);
		await_irq();
		close_checks(2);
		compare_words(16'h0010, 24'h000000, 2, 1'b1);
	endtask

	task automatic test_wake_read();
		irq_base = irq_count;
		write_reg(REG_CMD, 16'h0002);
		await_irq();
		expect_reg("status", REG_STATUS, 16'h0001);
		start_read(24'h000101, 16'h0040, 16'd4);
		await_irq();
		close_checks(4);
		compare_words(16'h0040, 24'h000101, 4, 1'b0);
		expect_reg("data", REG_DATA, expected_word(24'h000107));
	endtask

	task automatic test_backpressure();
		@(negedge CLK);
		throttle = 1'b1;
		start_read(24'h000101, 16'h0040, 16'd4);
		await_irq();
		close_checks(4);
		compare_words(16'h0040, 24'h000101, 4, 1'b0);
		@(negedge CLK);
		throttle = 1'b0;
	endtask

	task automatic test_go_while_busy();
		start_read(24'h000200, 16'h0060, 16'd3);
		expect_reg("status", REG_STATUS, 16'h0002);
		write_reg(REG_DMA_COUNT, 16'd6);
		write_reg(REG_CMD, 16'h0001); // Ignored while the transfer runs.
		await_irq();
		repeat (20) @(negedge CLK);
		close_checks(3);
		compare_words(16'h0060, 24'h000200, 3, 1'b0);
	endtask

	task automatic test_high_address();
		start_read(24'h01FFFE, 16'h0080, 16'd3);
		expect_reg("addr_hi", REG_ADDR_HI, 16'h0001);
		await_irq();
		// The pattern only follows the low address byte, so check the wire address too.
		check_word("rd_addr[15:0]", u_flash.rd_addr[15:0], 16'hFFFE);
		check_word("rd_addr[23:16]", {8'h00, u_flash.rd_addr[23:16]}, 16'h0001);
		close_checks(3);
		compare_words(16'h0080, 24'h01FFFE, 3, 1'b0);
	endtask

	initial begin
		RSTb    = 1'b0;
		address = '0;
		data_in = '0;
		wr      = 1'b0;
		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;
		@(negedge CLK);
		test_reset_state();
		test_read_asleep();
		test_wake_read();
		test_backpressure();
		test_go_while_busy();
		test_high_address();
		$display("Summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* logic/spi_flash_dma.sv */
`timescale 1ns/1ps

module spi_flash_dma import flash_pkg::*; #(
	parameter int SCK_DIV = 8
) (
	input  logic      CLK,
	input  logic      RSTb,
	input  reg_addr_t address,
	input  reg_word_t data_in,
	input  logic      wr,
	output reg_word_t data_out,
	output logic      MOSI,
	input  logic      MISO,
	output logic      SCK,
	output logic      CSb,
	output logic      wvalid,
	input  logic      wready,
	output mem_addr_t memory_address,
	output mem_data_t memory_data,
	output logic      irq
);

	flash_addr_t flash_addr;
	mem_addr_t   dma_addr;
	reg_word_t   dma_count;
	logic        go;
	logic        wake;
	logic        busy;
	logic        done_set;
	mem_data_t   rx_word;

	spi_if    spi_bus ();
	mem_wr_if mem_bus ();

	flash_regs u_regs (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.address    (address),
		.data_in    (data_in),
		.wr         (wr),
		.busy       (busy),
		.done_set   (done_set),
		.rx_word    (rx_word),
		.data_out   (data_out),
		.flash_addr (flash_addr),
		.dma_addr   (dma_addr),
		.dma_count  (dma_count),
		.go         (go),
		.wake       (wake)
	);

	flash_seq u_seq (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.go         (go),
		.wake       (wake),
		.flash_addr (flash_addr),
		.dma_addr   (dma_addr),
		.dma_count  (dma_count),
		.busy       (busy),
		.done_set   (done_set),
		.rx_word    (rx_word),
		.CSb        (CSb),
		.irq        (irq),
		.spi        (spi_bus.master),
		.mem        (mem_bus.source)
	);

	spi_shifter #(
		.SCK_DIV (SCK_DIV)
	) u_shifter (
		.CLK  (CLK),
		.RSTb (RSTb),
		.MISO (MISO),
		.MOSI (MOSI),
		.SCK  (SCK),
		.spi  (spi_bus.slave)
	);

	// Memory write channel out to the pins.
	assign wvalid          = mem_bus.wvalid;
	assign memory_address  = mem_bus.memory_address;
	assign memory_data     = mem_bus.memory_data;
	assign mem_bus.wready  = wready;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_spi_flash_dma -f compile.f \
	-Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
exit 1

/* spi_flash/flash_regs.sv */
`timescale 1ns/1ps

module flash_regs import flash_pkg::*; (
	input  logic        CLK,
	input  logic        RSTb,
	input  reg_addr_t   address,
	input  reg_word_t   data_in,
	input  logic        wr,
	input  logic        busy,
	input  logic        done_set,
	input  mem_data_t   rx_word,
	output reg_word_t   data_out,
	output flash_addr_t flash_addr,
	output mem_addr_t   dma_addr,
	output reg_word_t   dma_count,
	output logic        go,
	output logic        wake
);

	reg_word_t  addr_lo_r;
	logic [7:0] addr_hi_r;
	mem_addr_t  dma_addr_r;
	reg_word_t  dma_count_r;
	logic       go_r;
	logic       wake_r;
	logic       done_r;
	logic       cmd_accept;

	// A pending pulse counts as busy, the sequencer has not left idle yet.
	assign cmd_accept = wr && (address == REG_CMD) && !busy && !go_r && !wake_r;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			addr_lo_r   <= '0;
			addr_hi_r   <= '0;
			dma_addr_r  <= '0;
			dma_count_r <= '0;
			go_r        <= 1'b0;
			wake_r      <= 1'b0;
			done_r      <= 1'b0;
		end else begin
			go_r   <= cmd_accept & data_in[0];
			wake_r <= cmd_accept & data_in[1];

			if (wr) begin
				case (address)
					REG_ADDR_LO:   addr_lo_r   <= data_in;
					REG_ADDR_HI:   addr_hi_r   <= data_in[7:0];
					REG_DMA_ADDR:  dma_addr_r  <= data_in;
					REG_DMA_COUNT: dma_count_r <= data_in;
					default: ;
				endcase
			end

			// Sticky done, a new command clears it.
			if (cmd_accept && (data_in[1:0] != 2'b00))
				done_r <= 1'b0;
			else if (done_set)
				done_r <= 1'b1;
		end
	end

	assign flash_addr = {addr_hi_r, addr_lo_r};
	assign dma_addr   = dma_addr_r;
	assign dma_count  = dma_count_r;
	assign go         = go_r;
	assign wake       = wake_r;

	always_comb begin
		data_out = '0;
		case (address)
			REG_ADDR_LO:   data_out = addr_lo_r;
			REG_ADDR_HI:   data_out = {8'h00, addr_hi_r};
			REG_DATA:      data_out = {rx_word[7:0], rx_word[15:8]}; // First flash byte low.
			REG_STATUS:    data_out = {14'd0, busy, done_r};
			REG_DMA_ADDR:  data_out = dma_addr_r;
			REG_DMA_COUNT: data_out = dma_count_r;
			default: ;
		endcase
	end

endmodule

/* spi_flash/flash_seq.sv */
`timescale 1ns/1ps

module flash_seq import flash_pkg::*; (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic        go,
	input  logic        wake,
	input  flash_addr_t flash_addr,
	input  mem_addr_t   dma_addr,
	input  reg_word_t   dma_count,
	output logic        busy,
	output logic        done_set,
	output mem_data_t   rx_word,
	output logic        CSb,
	output logic        irq,
	spi_if.master       spi,
	mem_wr_if.source    mem
);

	localparam xfer_len_t LEN_CMD_ADDR = 6'd32;
	localparam xfer_len_t LEN_WAKE     = 6'd8;
	localparam xfer_len_t LEN_WORD     = 6'd16;

	seq_state_t  state_r;
	logic        cs_b_r;
	logic        start_r;
	logic        wvalid_r;
	mem_addr_t   cur_addr_r;
	reg_word_t   remain_r;
	reg_word_t   remain_next;
	mem_data_t   rx_word_r;
	logic [31:0] tx_data_r;
	xfer_len_t   tx_len_r;

	assign remain_next = remain_r - 16'd1;

	// ##########################################################
	// Phase sequencing
	// ##########################################################

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r    <= seq_idle;
			cs_b_r     <= 1'b1;
			start_r    <= 1'b0;
			wvalid_r   <= 1'b0;
			cur_addr_r <= '0;
			remain_r   <= '0;
			rx_word_r  <= '0;
		end else begin
			start_r <= 1'b0;
			case (state_r)
				seq_idle: begin
					if (go) begin
						cur_addr_r <= dma_addr;
						remain_r   <= dma_count;
						cs_b_r     <= 1'b0;
						start_r    <= 1'b1;
						state_r    <= seq_cmd_addr;
					end else if (wake) begin
						cs_b_r  <= 1'b0;
						start_r <= 1'b1;
						state_r <= seq_wake;
					end
				end
				seq_wake: begin
					if (spi.done) begin
						cs_b_r  <= 1'b1;
						state_r <= seq_finish;
					end
				end
				seq_cmd_addr: begin
					if (spi.done) begin
						start_r <= 1'b1; // First data word.
						state_r <= seq_data;
					end
				end
				seq_data: begin
					if (spi.done) begin
						rx_word_r <= spi.rx_data;
						wvalid_r  <= 1'b1;
						state_r   <= seq_mem_wr;
					end
				end
				seq_mem_wr: begin
					// SCK stays low here, so a stalled write just stretches the clock.
					if (mem.wready) begin
						wvalid_r   <= 1'b0;
						cur_addr_r <= cur_addr_r + 16'd1;
						remain_r   <= remain_next;
						if (remain_next == 16'd0) begin
							cs_b_r  <= 1'b1;
							state_r <= seq_finish;
						end else begin
							start_r <= 1'b1;
							state_r <= seq_data;
						end
					end
				end
				seq_finish: state_r <= seq_idle;
				default:    state_r <= seq_idle;
			endcase
		end
	end

	// Transfer setup, sampled by the shifter together with start.
	always_ff @(posedge CLK) begin
		if (state_r == seq_idle) begin
			if (go) begin
				tx_data_r <= {OP_READ, flash_addr};
				tx_len_r  <= LEN_CMD_ADDR;
			end else begin
				tx_data_r <= {OP_WAKE, 24'h000000};
				tx_len_r  <= LEN_WAKE;
			end
		end else begin
			tx_data_r <= '0; // Dummy bits while reading.
			tx_len_r  <= LEN_WORD;
		end
	end

	assign spi.start   = start_r;
	assign spi.tx_data = tx_data_r;
	assign spi.tx_len  = tx_len_r;

	assign mem.wvalid         = wvalid_r;
	assign mem.memory_address = cur_addr_r;
	assign mem.memory_data    = {rx_word_r[7:0], rx_word_r[15:8]}; // First flash byte low.

	assign busy     = (state_r != seq_idle);
	assign done_set = (state_r == seq_finish);
	assign irq      = (state_r == seq_finish);
	assign rx_word  = rx_word_r;
	assign CSb      = cs_b_r;

endmodule

/* spi_flash/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter import flash_pkg::*; #(
	parameter int SCK_DIV = 8
) (
	input  logic  CLK,
	input  logic  RSTb,
	input  logic  MISO,
	output logic  MOSI,
	output logic  SCK,
	spi_if.slave  spi
);

	localparam int TICK_W = $clog2(SCK_DIV);
	localparam logic [TICK_W-1:0] RISE_TICK = TICK_W'(SCK_DIV / 2 - 1);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(SCK_DIV - 1);

	logic              active_r;
	logic [TICK_W-1:0] tick_r;
	xfer_len_t         bit_cnt_r;
	xfer_len_t         len_r;
	xfer_len_t         last_bit;
	logic              done_r;
	logic [31:0]       shift_r;
	mem_data_t         rx_r;
	logic              load;
	logic              rise;
	logic              bit_end;

	assign last_bit = len_r - 6'd1;
	assign load     = !active_r && spi.start;
	assign rise     = active_r && (tick_r == RISE_TICK);
	assign bit_end  = active_r && (tick_r == LAST_TICK);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			active_r  <= 1'b0;
			tick_r    <= '0;
			bit_cnt_r <= '0;
			len_r     <= '0;
			done_r    <= 1'b0;
		end else begin
			done_r <= 1'b0;
			if (load) begin
				active_r  <= 1'b1;
				tick_r    <= '0;
				bit_cnt_r <= '0;
				len_r     <= spi.tx_len;
			end else if (active_r) begin
				tick_r <= tick_r + 1'b1; // Wraps to 0 at the end of each bit.
				if (bit_end) begin
					bit_cnt_r <= bit_cnt_r + 6'd1;
					if (bit_cnt_r == last_bit) begin
						active_r <= 1'b0;
						done_r   <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (load)
			shift_r <= spi.tx_data;
		else if (bit_end)
			shift_r <= {shift_r[30:0], 1'b0};
		if (rise)
			rx_r <= {rx_r[14:0], MISO}; // Sampled on the rising SCK.
	end

	// Low half first, high half second.
	assign SCK  = tick_r[TICK_W-1];
	assign MOSI = active_r & shift_r[31];

	assign spi.rx_data = rx_r;
	assign spi.done    = done_r;

endmodule
